// File: rtl/img_defs.svh
`ifndef IMG_DEFS_SVH
`define IMG_DEFS_SVH

// ====================
// Pixel and word widths
// ====================
`define IMG_PIXEL_BITS 12
`define IMG_WORD_BITS 16

// Largest frame the buffer can hold
`define IMG_WIDTH_MAX 16
`define IMG_HEIGHT_MAX 16

// ====================
// Buffer layout
// ====================
`define IMG_HEADER_WORDS 4
`define IMG_BUF_DEPTH (`IMG_HEADER_WORDS + `IMG_WIDTH_MAX * `IMG_HEIGHT_MAX)

// Readout flow control
`define IMG_CREDITS 4

// Grid statistics
`define IMG_STAT_BITS 10
`define IMG_STAT_MSBS 7

`endif

// File: rtl/img_types_pkg.sv
`include "img_defs.svh"

package img_types_pkg;

    // Raw camera sample and stored buffer word
    typedef logic [`IMG_PIXEL_BITS-1:0] pixel_t;
    typedef logic [`IMG_WORD_BITS-1:0] word_t;

    // Full header as given with the capture command
    typedef logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0] header_t;

    // Measured frame dimensions, wide enough to hold the maximum itself
    typedef logic [$clog2(`IMG_WIDTH_MAX+1)-1:0] dim_w_t;
    typedef logic [$clog2(`IMG_HEIGHT_MAX+1)-1:0] dim_h_t;

    // Highlight and shadow counters
    typedef logic [`IMG_STAT_BITS-1:0] stat_t;

    // Buffer address and word count
    typedef logic [$clog2(`IMG_BUF_DEPTH)-1:0] addr_t;
    typedef logic [$clog2(`IMG_BUF_DEPTH+1)-1:0] count_t;

    // Readout credits, 0 up to IMG_CREDITS
    typedef logic [$clog2(`IMG_CREDITS+1)-1:0] credit_t;

endpackage

// File: rtl/img_ctrl_pkg.sv
package img_ctrl_pkg;

    // ====================
    // Capture side FSM
    // ====================
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_INVALID,
        CAP_WAIT_START,
        CAP_ACTIVE
    } cap_state_t;

    // ====================
    // Sequencer FSM
    // ====================
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_HEADER,
        SEQ_CAPTURE,
        SEQ_READOUT
    } seq_state_t;

endpackage

// File: rtl/img_capture.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module img_capture import img_types_pkg::*, img_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   fifoIn_rst,
    input  pixel_t img_d,
    input  logic   img_fv,
    input  logic   img_lv,
    input  logic   capture_start,
    output logic   pixel_valid,
    output word_t  pixel_word,
    output logic   frame_done,
    output dim_w_t status_image_width,
    output dim_h_t status_image_height,
    output stat_t  status_highlight_count,
    output stat_t  status_shadow_count
);

    pixel_t img_d_q;
    logic fv_q;
    logic lv_q;
    logic lv_d;
    cap_state_t state;
    logic [1:0] col_q;
    logic [1:0] line_q;
    logic take_px;
    logic on_grid;
    logic [`IMG_STAT_MSBS-1:0] px_msbs;

    // ====================
    // Pin sampling
    // ====================
    always_ff @(posedge clk) begin
        img_d_q <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            fv_q <= 1'b0;
            lv_q <= 1'b0;
            lv_d <= 1'b0;
        end else begin
            fv_q <= img_fv;
            lv_q <= img_lv;
            lv_d <= lv_q;
        end
    end

    // A line may already be valid in the cycle the frame start is seen
    assign take_px = lv_q && fv_q && (state == CAP_ACTIVE || state == CAP_WAIT_START);
    assign px_msbs = img_d_q[`IMG_PIXEL_BITS-1 -: `IMG_STAT_MSBS];
    assign on_grid = take_px && (col_q == 2'd0) && (line_q == 2'd0);

    // ====================
    // Frame sync FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state       <= CAP_IDLE;
            pixel_valid <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            pixel_valid <= take_px;
            frame_done  <= 1'b0;
            case (state)
                CAP_IDLE: begin
                    if (capture_start) state <= CAP_WAIT_INVALID;
                end
                CAP_WAIT_INVALID: begin
                    if (!fv_q) state <= CAP_WAIT_START;
                end
                CAP_WAIT_START: begin
                    if (fv_q) state <= CAP_ACTIVE;
                end
                CAP_ACTIVE: begin
                    if (!fv_q) begin
                        state      <= CAP_IDLE;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // Zero-extend into the stored word
    always_ff @(posedge clk) begin
        pixel_word <= {{(`IMG_WORD_BITS-`IMG_PIXEL_BITS){1'b0}}, img_d_q};
    end

    // Sampling grid position, modulo 4
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            col_q  <= 2'd0;
            line_q <= 2'd0;
        end else begin
            col_q <= lv_q ? col_q + 2'd1 : 2'd0;
            if (!fv_q) line_q <= 2'd0;
            else if (lv_d && !lv_q) line_q <= line_q + 2'd1;
        end
    end

    // ====================
    // Dimensions and statistics
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || capture_start) begin
            status_image_width     <= '0;
            status_image_height    <= '0;
            status_highlight_count <= '0;
            status_shadow_count    <= '0;
        end else begin
            if (take_px) begin
                // First pixel of a line restarts the width
                if (!lv_d) begin
                    status_image_width  <= dim_w_t'(1);
                    status_image_height <= status_image_height + dim_h_t'(1);
                end else begin
                    status_image_width <= status_image_width + dim_w_t'(1);
                end
            end
            if (on_grid) begin
                if (px_msbs == '1) status_highlight_count <= status_highlight_count + 1'b1;
                else if (px_msbs == '0) status_shadow_count <= status_shadow_count + 1'b1;
            end
        end
    end

    // Pixels are only produced once the frame has started
    a_valid_active: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        pixel_valid |-> state == CAP_ACTIVE);

endmodule

// File: rtl/img_frame_buffer.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module img_frame_buffer import img_types_pkg::*; (
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  word_t wr_data,
    input  logic  rd_en,
    input  addr_t rd_addr,
    output word_t rd_data
);

    word_t mem [`IMG_BUF_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, data one cycle after rd_en and held otherwise
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    a_wr_range: assert property (@(posedge clk)
        wr_en |-> wr_addr < `IMG_BUF_DEPTH);

    a_rd_range: assert property (@(posedge clk)
        rd_en |-> rd_addr < `IMG_BUF_DEPTH);

endmodule

// File: rtl/img_sequencer.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module img_sequencer import img_types_pkg::*, img_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    fifoIn_rst,
    input  logic    cmd_capture,
    input  header_t cmd_header,
    input  count_t  cmd_pixel_count,
    input  logic    pixel_valid,
    input  word_t   pixel_word,
    input  logic    frame_done,
    input  logic    readout_done,
    output logic    capture_start,
    output logic    wr_en,
    output addr_t   wr_addr,
    output word_t   wr_data,
    output logic    readout_start,
    output count_t  readout_count,
    output logic    status_busy,
    output logic    status_capture_done
);

    seq_state_t state;
    header_t hdr_q;
    count_t count_q;
    addr_t wr_ptr;

    assign readout_count = count_q;

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state               <= SEQ_IDLE;
            wr_ptr              <= '0;
            wr_en               <= 1'b0;
            capture_start       <= 1'b0;
            readout_start       <= 1'b0;
            status_busy         <= 1'b0;
            status_capture_done <= 1'b0;
        end else begin
            wr_en               <= 1'b0;
            capture_start       <= 1'b0;
            readout_start       <= 1'b0;
            status_capture_done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (cmd_capture) begin
                        state       <= SEQ_HEADER;
                        wr_ptr      <= '0;
                        status_busy <= 1'b1;
                    end
                end
                SEQ_HEADER: begin
                    // One header word per cycle at addresses 0 to 3
                    wr_en  <= 1'b1;
                    wr_ptr <= wr_ptr + addr_t'(1);
                    if (wr_ptr == addr_t'(`IMG_HEADER_WORDS-1)) begin
                        state         <= SEQ_CAPTURE;
                        capture_start <= 1'b1;
                    end
                end
                SEQ_CAPTURE: begin
                    // Drop pixels beyond the end of the buffer
                    if (pixel_valid && wr_ptr < addr_t'(`IMG_BUF_DEPTH)) begin
                        wr_en  <= 1'b1;
                        wr_ptr <= wr_ptr + addr_t'(1);
                    end
                    if (frame_done) begin
                        state               <= SEQ_READOUT;
                        readout_start       <= 1'b1;
                        status_capture_done <= 1'b1;
                    end
                end
                SEQ_READOUT: begin
                    if (readout_done) begin
                        state       <= SEQ_IDLE;
                        status_busy <= 1'b0;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // ====================
    // Command latch and write data
    // ====================
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && cmd_capture) begin
            hdr_q <= cmd_header;
            // Never read past the buffer
            if (cmd_pixel_count > count_t'(`IMG_BUF_DEPTH)) begin
                count_q <= count_t'(`IMG_BUF_DEPTH);
            end else begin
                count_q <= cmd_pixel_count;
            end
        end else if (state == SEQ_HEADER) begin
            hdr_q <= hdr_q << `IMG_WORD_BITS;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= wr_ptr;
        if (state == SEQ_HEADER) begin
            // Most significant word goes first
            wr_data <= hdr_q[$bits(header_t)-1 -: `IMG_WORD_BITS];
        end else begin
            wr_data <= pixel_word;
        end
    end

    // Capture only produces pixels while the sequencer stores them
    a_pixel_in_capture: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        pixel_valid |-> state == SEQ_CAPTURE);

endmodule

// File: rtl/img_readout.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module img_readout import img_types_pkg::*; (
    input  logic   clk,
    input  logic   fifoIn_rst,
    input  logic   readout_start,
    input  count_t readout_count,
    input  word_t  rd_data,
    input  logic   readout_credit,
    output logic   rd_en,
    output addr_t  rd_addr,
    output logic   readout_valid,
    output word_t  readout_data,
    output logic   readout_done
);

    credit_t credits;
    count_t remaining;

    // Read whenever a word is left and the consumer has room for it
    assign rd_en = (remaining != '0) && (credits != '0);

    // Buffer data is already registered, valid follows the read by one cycle
    assign readout_data = rd_data;

    // ====================
    // Credit counter
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            credits <= credit_t'(`IMG_CREDITS);
        end else begin
            credits <= credits + credit_t'(readout_credit) - credit_t'(rd_en);
        end
    end

    // ====================
    // Address and word count
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            remaining <= '0;
            rd_addr   <= '0;
        end else if (readout_start) begin
            remaining <= readout_count;
            rd_addr   <= '0;
        end else if (rd_en) begin
            remaining <= remaining - count_t'(1);
            rd_addr   <= rd_addr + addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            readout_valid <= 1'b0;
            readout_done  <= 1'b0;
        end else begin
            readout_valid <= rd_en;
            // Finish with the last word, or at once for an empty readout
            readout_done  <= (rd_en && remaining == count_t'(1)) ||
                             (readout_start && readout_count == '0);
        end
    end

    // The consumer never hands back more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        credits <= credit_t'(`IMG_CREDITS));

endmodule

// File: rtl/img_controller_top.sv
`timescale 1ns/100ps

module img_controller_top import img_types_pkg::*; (
    input  logic    clk,
    input  logic    fifoIn_rst,
    // Command
    input  logic    cmd_capture,
    input  header_t cmd_header,
    input  count_t  cmd_pixel_count,
    // Camera
    input  pixel_t  img_d,
    input  logic    img_fv,
    input  logic    img_lv,
    // Readout
    output logic    readout_valid,
    output word_t   readout_data,
    input  logic    readout_credit,
    // Status
    output logic    status_busy,
    output logic    status_capture_done,
    output dim_w_t  status_image_width,
    output dim_h_t  status_image_height,
    output stat_t   status_highlight_count,
    output stat_t   status_shadow_count
);

    logic capture_start;
    logic pixel_valid;
    word_t pixel_word;
    logic frame_done;
    logic wr_en;
    addr_t wr_addr;
    word_t wr_data;
    logic rd_en;
    addr_t rd_addr;
    word_t rd_data;
    logic readout_start;
    count_t readout_count;
    logic readout_done;

    img_capture u_capture (
        .clk                    (clk),
        .fifoIn_rst             (fifoIn_rst),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .capture_start          (capture_start),
        .pixel_valid            (pixel_valid),
        .pixel_word             (pixel_word),
        .frame_done             (frame_done),
        .status_image_width     (status_image_width),
        .status_image_height    (status_image_height),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    img_frame_buffer u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    img_sequencer u_sequencer (
        .clk                 (clk),
        .fifoIn_rst          (fifoIn_rst),
        .cmd_capture         (cmd_capture),
        .cmd_header          (cmd_header),
        .cmd_pixel_count     (cmd_pixel_count),
        .pixel_valid         (pixel_valid),
        .pixel_word          (pixel_word),
        .frame_done          (frame_done),
        .readout_done        (readout_done),
        .capture_start       (capture_start),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .readout_start       (readout_start),
        .readout_count       (readout_count),
        .status_busy         (status_busy),
        .status_capture_done (status_capture_done)
    );

    img_readout u_readout (
        .clk            (clk),
        .fifoIn_rst     (fifoIn_rst),
        .readout_start  (readout_start),
        .readout_count  (readout_count),
        .rd_data        (rd_data),
        .readout_credit (readout_credit),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .readout_valid  (readout_valid),
        .readout_data   (readout_data),
        .readout_done   (readout_done)
    );

endmodule

// File: verif/img_model.svh
`ifndef IMG_MODEL_SVH
`define IMG_MODEL_SVH

// ====================
// Reference model
// ====================

// Pixels of the frame being sent, in raster order
pixel_t frame_px [`IMG_HEIGHT_MAX][`IMG_WIDTH_MAX];

// Expected readout stream and status values
word_t exp_words [$];
int    exp_width;
int    exp_height;
int    exp_highlight;
int    exp_shadow;

// Upper pixel bits that classify a sample
function automatic logic [`IMG_STAT_MSBS-1:0] upper_bits(pixel_t p);
    return p[`IMG_PIXEL_BITS-1 -: `IMG_STAT_MSBS];
endfunction

// Header words first, most significant word first, then the pixels
task automatic build_expected(header_t hdr, int w, int h);
    exp_words.delete();
    for (int i = `IMG_HEADER_WORDS - 1; i >= 0; i--) begin
        exp_words.push_back(hdr[i*`IMG_WORD_BITS +: `IMG_WORD_BITS]);
    end
    exp_width     = w;
    exp_height    = h;
    exp_highlight = 0;
    exp_shadow    = 0;
    for (int r = 0; r < h; r++) begin
        for (int c = 0; c < w; c++) begin
            exp_words.push_back(word_t'(frame_px[r][c]));
            // Grid of every fourth column on every fourth line
            if (r % 4 == 0 && c % 4 == 0) begin
                if (upper_bits(frame_px[r][c]) == '1) exp_highlight++;
                else if (upper_bits(frame_px[r][c]) == '0) exp_shadow++;
            end
        end
    end
endtask

`endif

// File: verif/img_tb.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module img_tb
    import img_types_pkg::*;
();

    logic    clk;
    logic    fifoIn_rst;
    logic    cmd_capture;
    header_t cmd_header;
    count_t  cmd_pixel_count;
    pixel_t  img_d;
    logic    img_fv;
    logic    img_lv;
    logic    readout_valid;
    word_t   readout_data;
    logic    readout_credit;
    logic    status_busy;
    logic    status_capture_done;
    dim_w_t  status_image_width;
    dim_h_t  status_image_height;
    stat_t   status_highlight_count;
    stat_t   status_shadow_count;

    int words_seen = 0;
    int received = 0;
    int returned = 0;
    int done_count = 0;
    int credit_due [$];

    `include "img_model.svh"

    img_controller_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Error reporting
    // ====================
    task automatic stop_run(string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string what);
        stop_run($sformatf("MISMATCH at %0d ns: %s", $time, what));
    endtask

    task automatic wait_busy(logic level, int limit, string what);
        int n;
        n = 0;
        while (status_busy !== level) begin
            @(negedge clk);
            n++;
            assert (n <= limit) else stop_run($sformatf("Timeout: %s", what));
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    // About a third of the pixels sit at full scale or zero in the upper bits
    function automatic pixel_t random_pixel();
        pixel_t p;
        int kind;
        p = pixel_t'($urandom);
        kind = $urandom_range(0, 5);
        if (kind == 0) p[`IMG_PIXEL_BITS-1 -: `IMG_STAT_MSBS] = '1;
        else if (kind == 1) p[`IMG_PIXEL_BITS-1 -: `IMG_STAT_MSBS] = '0;
        return p;
    endfunction

    task automatic drive_cycle(logic fv, logic lv, pixel_t d, logic stray);
        @(negedge clk);
        img_fv = fv;
        img_lv = lv;
        img_d = d;
        cmd_capture = stray;
        // A command with other values while busy must be ignored
        if (stray) begin
            cmd_header = ~cmd_header;
            cmd_pixel_count = count_t'($urandom_range(1, `IMG_BUF_DEPTH));
        end
    endtask

    task automatic send_frame(int w, int h);
        drive_cycle(1'b1, 1'b0, '0, 1'b0);
        for (int r = 0; r < h; r++) begin
            drive_cycle(1'b1, 1'b0, '0, r == h / 2);
            repeat ($urandom_range(0, 2)) drive_cycle(1'b1, 1'b0, '0, 1'b0);
            for (int c = 0; c < w; c++) begin
                drive_cycle(1'b1, 1'b1, frame_px[r][c], 1'b0);
            end
        end
        repeat ($urandom_range(1, 3)) drive_cycle(1'b1, 1'b0, '0, 1'b0);
        drive_cycle(1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic run_frame(int frame_no);
        int w;
        int h;
        int dones_before;
        header_t hdr;
        count_t cnt;
        w = $urandom_range(1, `IMG_WIDTH_MAX);
        h = $urandom_range(1, `IMG_HEIGHT_MAX);
        hdr = {$urandom, $urandom};
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) frame_px[r][c] = random_pixel();
        end
        build_expected(hdr, w, h);
        cnt = count_t'(`IMG_HEADER_WORDS + w * h);
        words_seen = 0;
        dones_before = done_count;
        repeat ($urandom_range(1, 5)) @(negedge clk);
        cmd_capture = 1'b1;
        cmd_header = hdr;
        cmd_pixel_count = cnt;
        @(negedge clk);
        cmd_capture = 1'b0;
        wait_busy(1'b1, 2, $sformatf("frame %0d, status_busy did not rise", frame_no));
        // Frame invalid while the header is written and capture arms
        repeat (8 + $urandom_range(0, 4)) @(negedge clk);
        send_frame(w, h);
        wait_busy(1'b0, 4000, $sformatf("frame %0d, readout never finished", frame_no));
        assert (words_seen - `IMG_HEADER_WORDS == int'(cnt) - `IMG_HEADER_WORDS)
            else report_mismatch($sformatf("frame %0d gave %0d pixel words, expected %0d",
                frame_no, words_seen - `IMG_HEADER_WORDS, int'(cnt) - `IMG_HEADER_WORDS));
        assert (done_count == dones_before + 1)
            else report_mismatch($sformatf("frame %0d gave %0d capture-done pulses",
                frame_no, done_count - dones_before));
        repeat (6) begin
            @(negedge clk);
            assert (status_busy === 1'b0)
                else stop_run("status_busy rose again without a new command");
        end
    endtask

    // ====================
    // Consumer and status checks
    // ====================
    task automatic take_word(word_t w);
        word_t exp_w;
        assert (exp_words.size() != 0)
            else stop_run("Readout delivered more words than commanded");
        exp_w = exp_words.pop_front();
        assert (w === exp_w)
            else report_mismatch($sformatf("word %0d is %h, expected %h", words_seen, w, exp_w));
        words_seen++;
        received++;
        assert (received - returned <= `IMG_CREDITS)
            else stop_run("More words outstanding than credits allow");
    endtask

    task automatic check_status();
        assert (int'(status_image_width) == exp_width)
            else report_mismatch($sformatf("width %0d, expected %0d",
                status_image_width, exp_width));
        assert (int'(status_image_height) == exp_height)
            else report_mismatch($sformatf("height %0d, expected %0d",
                status_image_height, exp_height));
        assert (int'(status_highlight_count) == exp_highlight)
            else report_mismatch($sformatf("highlight count %0d, expected %0d",
                status_highlight_count, exp_highlight));
        assert (int'(status_shadow_count) == exp_shadow)
            else report_mismatch($sformatf("shadow count %0d, expected %0d",
                status_shadow_count, exp_shadow));
    endtask

    // Credits go back after 0 to 6 cycles and at most one per cycle
    initial begin : consumer
        int now;
        int pick;
        now = 0;
        readout_credit = 1'b0;
        forever begin
            @(negedge clk);
            now++;
            readout_credit = 1'b0;
            if (readout_valid === 1'b1) begin
                take_word(readout_data);
                credit_due.push_back(now + int'($urandom_range(0, 6)));
            end
            pick = -1;
            foreach (credit_due[i]) begin
                if (pick < 0 && credit_due[i] <= now) pick = i;
            end
            if (pick >= 0) begin
                credit_due.delete(pick);
                readout_credit = 1'b1;
                returned++;
            end
        end
    end

    initial begin : status_monitor
        forever begin
            @(negedge clk);
            if (status_capture_done === 1'b1) begin
                check_status();
                done_count++;
            end
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(95710));
        fifoIn_rst = 1'b0;
        cmd_capture = 1'b0;
        cmd_header = '0;
        cmd_pixel_count = '0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        fifoIn_rst = 1'b1;
        @(negedge clk);
        assert (readout_valid === 1'b0 && status_busy === 1'b0 &&
                status_capture_done === 1'b0)
            else report_mismatch("readout or status outputs not low after reset");
        for (int f = 0; f < 3; f++) run_frame(f);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: project.f
+incdir+rtl
+incdir+verif
rtl/img_types_pkg.sv
rtl/img_ctrl_pkg.sv
rtl/img_capture.sv
rtl/img_frame_buffer.sv
rtl/img_sequencer.sv
rtl/img_readout.sv
rtl/img_controller_top.sv
verif/img_tb.sv

// File: Bender.yml
package:
  name: img_controller

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/img_types_pkg.sv
      - rtl/img_ctrl_pkg.sv
      - rtl/img_capture.sv
      - rtl/img_frame_buffer.sv
      - rtl/img_sequencer.sv
      - rtl/img_readout.sv
      - rtl/img_controller_top.sv
  - target: test
    include_dirs:
      - rtl
      - verif
    files:
      - verif/img_tb.sv
